// ==== Makefile ====
# Verilator simulation of the serial update receiver

VERILATOR ?= verilator
TOP       ?= tbUsbWrapper
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= TEST PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hw/idleTimer.sv ====
`timescale 1ns/100ps
`default_nettype none

module idleTimer
(
    input  wire   iSysClk,
    input  wire   rstN,
    input  wire   restart,  // any received byte
    output logic  timeout   // single pulse per idle period
);

    import usbUpdatePkg::*;

    logic [timerWidth-1:0] cnt;
    logic                  expired;  // holds off repeat pulses

    always_ff @(posedge iSysClk)
    begin
        if (!rstN || restart)
        begin
            cnt     <= '0;
            expired <= 1'b0;
            timeout <= 1'b0;
        end
        else
        begin
            timeout <= 1'b0;
            if (!expired)
            begin
                if (cnt == timerWidth'(timeoutCycles - 1))
                begin
                    expired <= 1'b1;
                    timeout <= 1'b1;
                end
                else
                    cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/uartRx.sv ====
`timescale 1ns/100ps
`default_nettype none

module uartRx
(
    input  wire                                   iSysClk,
    input  wire                                   rstN,
    input  wire                                   rxd,      // serial in, idle high
    output logic [usbUpdatePkg::dataWidth-1:0]    rxData,   // held until next byte
    output logic                                  rxValid   // one-cycle strobe
);

    import usbUpdatePkg::*;

    // --------------------
    // two-flop synchronizer
    logic rxMeta;
    logic rxSync;

    always_ff @(posedge iSysClk)
    begin
        if (!rstN)
        begin
            rxMeta <= 1'b1;  // line idles high
            rxSync <= 1'b1;
        end
        else
        begin
            rxMeta <= rxd;
            rxSync <= rxMeta;
        end
    end

    // --------------------
    // frame sampling
    logic                 busy;       // frame in progress
    logic [3:0]           bitCnt;     // 0 start, 1..8 data, 9 stop
    logic [divWidth-1:0]  clkCnt;
    logic [divWidth-1:0]  bitEnd;     // sample point of current bit
    logic [dataWidth-1:0] shiftReg;
    logic                 sampleNow;

    // half a bit for the start check, full bits after that
    assign bitEnd    = (bitCnt == 4'd0) ? divWidth'(clkDiv / 2 - 1) : divWidth'(clkDiv - 1);
    assign sampleNow = busy && (clkCnt == bitEnd);

    always_ff @(posedge iSysClk)
    begin
        if (!rstN)
        begin
            busy    <= 1'b0;
            bitCnt  <= '0;
            clkCnt  <= '0;
            rxValid <= 1'b0;
        end
        else
        begin
            rxValid <= 1'b0;  // strobe by default low
            if (!busy)
            begin
                if (!rxSync)  // falling edge of start bit
                begin
                    busy   <= 1'b1;
                    bitCnt <= '0;
                    clkCnt <= '0;
                end
            end
            else if (!sampleNow)
            begin
                clkCnt <= clkCnt + 1'b1;
            end
            else
            begin
                clkCnt <= '0;
                bitCnt <= bitCnt + 1'b1;
                if (bitCnt == 4'd0 && rxSync)
                    busy <= 1'b0;  // glitch, start bit gone at mid-bit
                else if (bitCnt == 4'(dataWidth + 1))
                begin
                    busy    <= 1'b0;
                    rxValid <= rxSync;  // framing error drops the byte
                end
            end
        end
    end

    // payload path
    always_ff @(posedge iSysClk)
    begin
        if (sampleNow && bitCnt >= 4'd1 && bitCnt <= 4'(dataWidth))
            shiftReg <= {rxSync, shiftReg[dataWidth-1:1]};  // lsb first
        if (sampleNow && bitCnt == 4'(dataWidth + 1) && rxSync)
            rxData <= shiftReg;
    end

endmodule

`default_nettype wire

// ==== hw/uartTx.sv ====
`timescale 1ns/100ps
`default_nettype none

module uartTx
(
    input  wire                                   iSysClk,
    input  wire                                   rstN,
    input  wire                                   send,      // byte strobe
    input  wire [usbUpdatePkg::dataWidth-1:0]     sendData,
    output logic                                  txd        // serial out, idle high
);

    import usbUpdatePkg::*;

    // --------------------
    // 8N1 frame shifter
    logic                 busy;
    logic [3:0]           bitCnt;    // bit currently on the line
    logic [divWidth-1:0]  clkCnt;
    logic [dataWidth:0]   shiftReg;  // data bits then stop bit
    logic                 bitDone;

    assign bitDone = (clkCnt == divWidth'(clkDiv - 1));

    always_ff @(posedge iSysClk)
    begin
        if (!rstN)
        begin
            busy   <= 1'b0;
            bitCnt <= '0;
            clkCnt <= '0;
            txd    <= 1'b1;
        end
        else if (!busy)
        begin
            if (send)  // strobes during a frame are dropped
            begin
                busy   <= 1'b1;
                bitCnt <= '0;
                clkCnt <= '0;
                txd    <= 1'b0;  // start bit
            end
        end
        else if (!bitDone)
        begin
            clkCnt <= clkCnt + 1'b1;
        end
        else
        begin
            clkCnt <= '0;
            if (bitCnt == 4'(dataWidth + 1))  // stop bit served
            begin
                busy <= 1'b0;
                txd  <= 1'b1;
            end
            else
            begin
                bitCnt <= bitCnt + 1'b1;
                txd    <= shiftReg[0];
            end
        end
    end

    // frame payload, loaded with stop bit on top
    always_ff @(posedge iSysClk)
    begin
        if (!busy && send)
            shiftReg <= {1'b1, sendData};
        else if (busy && bitDone)
            shiftReg <= {1'b1, shiftReg[dataWidth:1]};
    end

endmodule

`default_nettype wire

// ==== hw/updateCtrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module updateCtrl
(
    input  wire                                   iSysClk,
    input  wire                                   rstN,
    input  wire                                   rxValid,      // byte strobe from uart
    input  wire [usbUpdatePkg::dataWidth-1:0]     rxData,
    input  wire                                   timeout,      // idle timer expired
    input  wire                                   wdVd,         // consumer took the byte
    input  wire                                   pdCmdCke,     // page program finished
    output logic [usbUpdatePkg::addrWidth-1:0]    addr,
    output logic [usbUpdatePkg::dataWidth-1:0]    pixelUpdate,
    output logic                                  pixelCke,
    output logic [usbUpdatePkg::dataWidth-1:0]    soundUpdate,
    output logic                                  soundCke
);

    import usbUpdatePkg::*;

    ctrlState state;

    // --------------------
    // stream select FSM
    always_ff @(posedge iSysClk)
    begin
        if (!rstN)
            state <= stIdle;
        else
        begin
            case (state)
                stIdle:
                begin
                    if (rxValid && rxData == startPixel)
                        state <= stPixel;
                    else if (rxValid && rxData == startSound)
                        state <= stSound;
                    // other bytes in idle only get echoed
                end
                stPixel, stSound:
                begin
                    if (timeout)
                        state <= stIdle;
                end
                default:
                    state <= stIdle;
            endcase
        end
    end

    // --------------------
    // data routing
    // idle keeps both streams at zero
    always_ff @(posedge iSysClk)
    begin
        case (state)
            stPixel:
            begin
                soundUpdate <= '0;
                if (rxValid)
                    pixelUpdate <= rxData;
            end
            stSound:
            begin
                pixelUpdate <= '0;
                if (rxValid)
                    soundUpdate <= rxData;
            end
            default:
            begin
                pixelUpdate <= '0;
                soundUpdate <= '0;
            end
        endcase
    end

    // --------------------
    // valid flags
    always_ff @(posedge iSysClk)
    begin
        if (!rstN || state == stIdle)
        begin
            pixelCke <= 1'b0;
            soundCke <= 1'b0;
        end
        else if (wdVd)  // consumption wins over a new byte
        begin
            pixelCke <= 1'b0;
            soundCke <= 1'b0;
        end
        else if (rxValid)
        begin
            pixelCke <= (state == stPixel);
            soundCke <= (state == stSound);
        end
    end

    // --------------------
    // flash page address
    // column is always written in full, so step a whole page
    always_ff @(posedge iSysClk)
    begin
        if (!rstN || state == stIdle)
            addr <= '0;
        else if (pdCmdCke)
            addr <= addr + pageStep;  // block carry falls out of the add
    end

endmodule

`default_nettype wire

// ==== hw/usbUpdatePkg.sv ====
`default_nettype none

package usbUpdatePkg;

    // --------------------
    // serial link
    localparam int dataWidth = 8;                 // uart byte and stream data
    localparam int clkDiv    = 868;               // 100 MHz / 115200 bps
    localparam int divWidth  = $clog2(clkDiv);    // bit-time counter width

    // --------------------
    // flash addressing
    // block 26:17, page 16:11, column 10:0
    localparam int addrWidth = 27;
    localparam logic [addrWidth-1:0] pageStep = 27'h000_0800;  // one column field

    // --------------------
    // idle timeout
    localparam int timeoutCycles = 20000;                  // scaled down for sim
    localparam int timerWidth    = $clog2(timeoutCycles);  // holds 0..timeoutCycles-1

    // start codes seen in idle
    localparam logic [dataWidth-1:0] startPixel = 8'h00;
    localparam logic [dataWidth-1:0] startSound = 8'h01;

    // stream select states
    typedef enum logic [1:0]
    {
        stIdle,
        stPixel,
        stSound
    } ctrlState;

endpackage

`default_nettype wire

// ==== hw/usbWrapper.sv ====
`timescale 1ns/100ps
`default_nettype none

module usbWrapper
(
    input  wire                                   iSysClk,
    input  wire                                   rstN,
    input  wire                                   rxd,          // host serial in
    output logic                                  txd,          // echo back to host
    input  wire                                   wdVd,
    input  wire                                   pdCmdCke,
    output logic [usbUpdatePkg::addrWidth-1:0]    addr,
    output logic [usbUpdatePkg::dataWidth-1:0]    pixelUpdate,
    output logic                                  pixelCke,
    output logic [usbUpdatePkg::dataWidth-1:0]    soundUpdate,
    output logic                                  soundCke
);

    import usbUpdatePkg::*;

    logic [dataWidth-1:0] rxData;
    logic                 rxValid;
    logic                 timeout;

    // --------------------
    // serial receive
    uartRx u_uartRx
    (
        .iSysClk (iSysClk),
        .rstN    (rstN),
        .rxd     (rxd),
        .rxData  (rxData),
        .rxValid (rxValid)
    );

    // echo every byte so the host can verify the link
    uartTx u_uartTx
    (
        .iSysClk  (iSysClk),
        .rstN     (rstN),
        .send     (rxValid),
        .sendData (rxData),
        .txd      (txd)
    );

    // restart on each byte
    idleTimer u_idleTimer
    (
        .iSysClk (iSysClk),
        .rstN    (rstN),
        .restart (rxValid),
        .timeout (timeout)
    );

    // --------------------
    // stream control
    updateCtrl u_updateCtrl
    (
        .iSysClk     (iSysClk),
        .rstN        (rstN),
        .rxValid     (rxValid),
        .rxData      (rxData),
        .timeout     (timeout),
        .wdVd        (wdVd),
        .pdCmdCke    (pdCmdCke),
        .addr        (addr),
        .pixelUpdate (pixelUpdate),
        .pixelCke    (pixelCke),
        .soundUpdate (soundUpdate),
        .soundCke    (soundCke)
    );

endmodule

`default_nettype wire

// ==== sources.f ====
hw/usbUpdatePkg.sv
hw/uartRx.sv
hw/uartTx.sv
hw/idleTimer.sv
hw/updateCtrl.sv
hw/usbWrapper.sv
test/tbClkGen.sv
test/tbChecker.sv
test/tbUsbWrapper.sv

// ==== test/tbChecker.sv ====
`timescale 1ns/100ps
`default_nettype none

module tbChecker
(
    input  wire                                   iSysClk,
    input  wire                                   rstN,
    input  wire                                   txd,
    input  wire [usbUpdatePkg::addrWidth-1:0]     addr,
    input  wire [usbUpdatePkg::dataWidth-1:0]     pixelUpdate,
    input  wire                                   pixelCke,
    input  wire [usbUpdatePkg::dataWidth-1:0]     soundUpdate,
    input  wire                                   soundCke,
    input  wire                                   checkReq,     // compare outputs now
    input  wire                                   sentStrobe,   // byte went out on rxd
    input  wire                                   summaryReq,
    input  wire [8*12-1:0]                        testName,
    input  wire [usbUpdatePkg::dataWidth-1:0]     sentByte,
    input  wire [usbUpdatePkg::dataWidth-1:0]     expPixel,
    input  wire                                   expPixelCke,
    input  wire [usbUpdatePkg::dataWidth-1:0]     expSound,
    input  wire                                   expSoundCke,
    input  wire [usbUpdatePkg::addrWidth-1:0]     expAddr,
    output int                                    echoCount,
    output int                                    errTotal,
    output logic                                  summaryDone
);

    import usbUpdatePkg::*;

    localparam int maxSent = 64;

    logic [dataWidth-1:0] sentBytes [maxSent];  // echo expectations, in send order
    logic [8*12-1:0]      sentNames [maxSent];
    int                   sentCount   = 0;
    int                   passCount   = 0;
    int                   failCount   = 0;
    int                   missing     = 0;
    int                   echoFails   = 0;  // written by the decoder only
    int                   echoSeen    = 0;
    int                   errSum      = 0;
    logic                 summaryFlag = 1'b0;
    logic [dataWidth-1:0] echoByte;
    int                   bitIdx;
    int                   k;

    assign echoCount   = echoSeen;
    assign errTotal    = errSum;
    assign summaryDone = summaryFlag;

    // --------------------
    // output compare, sampled mid-cycle
    always @(negedge iSysClk)
    begin
        if (sentStrobe && sentCount < maxSent)
        begin
            sentBytes[sentCount] = sentByte;
            sentNames[sentCount] = testName;
            sentCount++;
        end
        if (checkReq)
        begin
            if (pixelUpdate !== expPixel || pixelCke !== expPixelCke ||
                soundUpdate !== expSound || soundCke !== expSoundCke || addr !== expAddr)
            begin
                $display("Mismatch %0s: expected pix=%h/%b snd=%h/%b addr=%h",
                         testName, expPixel, expPixelCke, expSound, expSoundCke, expAddr,
                         " actual pix=%h/%b snd=%h/%b addr=%h",
                         pixelUpdate, pixelCke, soundUpdate, soundCke, addr);
                failCount++;
            end
            else
            begin
                $display("ok       %0s", testName);
                passCount++;
            end
        end
        if (summaryReq && !summaryFlag)
        begin
            for (k = echoSeen; k < sentCount; k++)  // bytes whose echo never showed
            begin
                $display("no echo frame came back for byte %h of %0s",
                         sentBytes[k], sentNames[k]);
                missing++;
            end
            errSum = failCount + echoFails + missing;
            $display("tests run %0d, passed %0d, failed %0d, echo errors %0d",
                     passCount + failCount, passCount, failCount, echoFails + missing);
            summaryFlag = 1'b1;
        end
    end

    // --------------------
    // txd frame decoder, mid-bit sampling
    initial
    begin
        wait (rstN);
        forever
        begin
            @(negedge iSysClk);
            if (!txd)  // start edge
            begin
                repeat (clkDiv / 2) @(negedge iSysClk);
                if (txd)
                begin
                    $display("echo start bit did not stay low until mid-bit");
                    echoFails++;
                end
                else
                begin
                    for (bitIdx = 0; bitIdx < dataWidth; bitIdx++)
                    begin
                        repeat (clkDiv) @(negedge iSysClk);
                        echoByte[bitIdx] = txd;  // lsb first
                    end
                    repeat (clkDiv) @(negedge iSysClk);  // stop bit
                    if (echoSeen >= sentCount)
                    begin
                        $display("echo frame %h arrived with no byte sent", echoByte);
                        echoFails++;
                    end
                    else
                    begin
                        if (!txd)
                        begin
                            $display("echo frame for %0s has a low stop bit",
                                     sentNames[echoSeen]);
                            echoFails++;
                        end
                        else if (echoByte !== sentBytes[echoSeen])
                        begin
                            $display("Mismatch echo of %0s: expected %h actual %h",
                                     sentNames[echoSeen], sentBytes[echoSeen], echoByte);
                            echoFails++;
                        end
                        echoSeen++;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/tbClkGen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tbClkGen
(
    output logic iSysClk,
    output logic rstN
);

    localparam int halfPeriod  = 10;  // 20 ns clock
    localparam int resetCycles = 5;

    // free running clock
    initial
    begin
        iSysClk = 1'b0;
        forever
            #(halfPeriod) iSysClk = ~iSysClk;
    end

    // sync reset, released on a rising edge
    initial
    begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge iSysClk);
        rstN <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== test/tbUsbWrapper.sv ====
`timescale 1ns/100ps
`default_nettype none

module tbUsbWrapper;

    import usbUpdatePkg::*;

    localparam int maxEntries = 32;
    localparam int opSend     = 0;
    localparam int opWd       = 1;
    localparam int opPage     = 2;
    localparam int opTimeout  = 3;

    logic                 iSysClk;
    logic                 rstN;
    logic                 rxd;
    logic                 txd;
    logic                 wdVd;
    logic                 pdCmdCke;
    logic [addrWidth-1:0] addr;
    logic [dataWidth-1:0] pixelUpdate;
    logic                 pixelCke;
    logic [dataWidth-1:0] soundUpdate;
    logic                 soundCke;

    // checker side
    logic                 checkReq;
    logic                 sentStrobe;
    logic                 summaryReq;
    logic [8*12-1:0]      curName;
    logic [dataWidth-1:0] sentByte;
    logic [dataWidth-1:0] expPixel;
    logic                 expPixelCke;
    logic [dataWidth-1:0] expSound;
    logic                 expSoundCke;
    logic [addrWidth-1:0] expAddr;
    int                   echoCount;
    int                   errTotal;
    logic                 summaryDone;

    // --------------------
    // stimulus table
    logic [8*12-1:0]      tName [maxEntries];
    int                   tOp   [maxEntries];
    logic [dataWidth-1:0] tData [maxEntries];
    logic [dataWidth-1:0] tPix  [maxEntries];
    logic                 tPcke [maxEntries];
    logic [dataWidth-1:0] tSnd  [maxEntries];
    logic                 tScke [maxEntries];
    logic [addrWidth-1:0] tAddr [maxEntries];
    int                   numEntries;
    int                   sentCount;
    int                   seed;
    int                   drainCnt;
    int                   watchLimit;
    logic                 tableReady;

    tbClkGen u_tbClkGen
    (
        .iSysClk (iSysClk),
        .rstN    (rstN)
    );

    usbWrapper u_usbWrapper
    (
        .iSysClk     (iSysClk),
        .rstN        (rstN),
        .rxd         (rxd),
        .txd         (txd),
        .wdVd        (wdVd),
        .pdCmdCke    (pdCmdCke),
        .addr        (addr),
        .pixelUpdate (pixelUpdate),
        .pixelCke    (pixelCke),
        .soundUpdate (soundUpdate),
        .soundCke    (soundCke)
    );

    tbChecker u_tbChecker
    (
        .iSysClk     (iSysClk),
        .rstN        (rstN),
        .txd         (txd),
        .addr        (addr),
        .pixelUpdate (pixelUpdate),
        .pixelCke    (pixelCke),
        .soundUpdate (soundUpdate),
        .soundCke    (soundCke),
        .checkReq    (checkReq),
        .sentStrobe  (sentStrobe),
        .summaryReq  (summaryReq),
        .testName    (curName),
        .sentByte    (sentByte),
        .expPixel    (expPixel),
        .expPixelCke (expPixelCke),
        .expSound    (expSound),
        .expSoundCke (expSoundCke),
        .expAddr     (expAddr),
        .echoCount   (echoCount),
        .errTotal    (errTotal),
        .summaryDone (summaryDone)
    );

    task automatic addEntry(input logic [8*12-1:0] name, input int op,
                            input logic [dataWidth-1:0] data,
                            input logic [dataWidth-1:0] pix, input logic pcke,
                            input logic [dataWidth-1:0] snd, input logic scke,
                            input logic [addrWidth-1:0] ad);
        tName[numEntries] = name;
        tOp[numEntries]   = op;
        tData[numEntries] = data;
        tPix[numEntries]  = pix;
        tPcke[numEntries] = pcke;
        tSnd[numEntries]  = snd;
        tScke[numEntries] = scke;
        tAddr[numEntries] = ad;
        numEntries++;
    endtask

    task automatic buildTable();
        logic [dataWidth-1:0] r1;
        logic [dataWidth-1:0] r2;
        logic [dataWidth-1:0] r3;
        logic [dataWidth-1:0] r4;
        logic [dataWidth-1:0] r5;
        r1 = 8'($random(seed));  // stream filler
        r2 = 8'($random(seed));
        r3 = 8'($random(seed));
        r4 = 8'($random(seed));
        r5 = 8'($random(seed));
        //        name          op         data   pix pC snd  sC addr
        addEntry("idleJunk",   opSend,    8'hA5, 0,  0, 0,  0, 27'h0000000);
        addEntry("pixStart",   opSend,    8'h00, 0,  0, 0,  0, 27'h0000000);
        addEntry("pixByte1",   opSend,    r1,    r1, 1, 0,  0, 27'h0000000);
        addEntry("pixByte2",   opSend,    r2,    r2, 1, 0,  0, 27'h0000000);
        addEntry("pixConsume", opWd,      0,     r2, 0, 0,  0, 27'h0000000);
        addEntry("pixPage1",   opPage,    0,     r2, 0, 0,  0, 27'h0000800);
        addEntry("pixByte3",   opSend,    r3,    r3, 1, 0,  0, 27'h0000800);
        addEntry("pixPage2",   opPage,    0,     r3, 1, 0,  0, 27'h0001000);
        addEntry("pixTimeout", opTimeout, 0,     0,  0, 0,  0, 27'h0000000);
        addEntry("idleJunk2",  opSend,    8'h7E, 0,  0, 0,  0, 27'h0000000);
        addEntry("idlePage",   opPage,    0,     0,  0, 0,  0, 27'h0000000);
        addEntry("sndStart",   opSend,    8'h01, 0,  0, 0,  0, 27'h0000000);
        addEntry("sndByte1",   opSend,    r4,    0,  0, r4, 1, 27'h0000000);
        addEntry("sndPage1",   opPage,    0,     0,  0, r4, 1, 27'h0000800);
        addEntry("sndConsume", opWd,      0,     0,  0, r4, 0, 27'h0000800);
        addEntry("sndByte2",   opSend,    r5,    0,  0, r5, 1, 27'h0000800);
        addEntry("sndPage2",   opPage,    0,     0,  0, r5, 1, 27'h0001000);
        addEntry("sndPage3",   opPage,    0,     0,  0, r5, 1, 27'h0001800);
        addEntry("sndTimeout", opTimeout, 0,     0,  0, 0,  0, 27'h0000000);
        addEntry("idleWd",     opWd,      0,     0,  0, 0,  0, 27'h0000000);
    endtask

    // one 8N1 frame on rxd
    task automatic sendFrame(input logic [dataWidth-1:0] b);
        int i;
        @(posedge iSysClk);
        rxd <= 1'b0;  // start bit
        repeat (clkDiv) @(posedge iSysClk);
        for (i = 0; i < dataWidth; i++)
        begin
            rxd <= b[i];
            repeat (clkDiv) @(posedge iSysClk);
        end
        rxd <= 1'b1;  // stop bit
        repeat (clkDiv) @(posedge iSysClk);
    endtask

    task automatic applyEntry(input int n);
        case (tOp[n])
            opSend:
            begin
                @(posedge iSysClk);
                sentStrobe <= 1'b1;  // tell checker which echo to expect
                sentByte   <= tData[n];
                curName    <= tName[n];
                @(posedge iSysClk);
                sentStrobe <= 1'b0;
                sentCount++;
                sendFrame(tData[n]);
            end
            opWd, opPage:
            begin
                @(posedge iSysClk);
                wdVd     <= (tOp[n] == opWd);
                pdCmdCke <= (tOp[n] == opPage);
                @(posedge iSysClk);
                wdVd     <= 1'b0;
                pdCmdCke <= 1'b0;
            end
            default:
                repeat (timeoutCycles) @(posedge iSysClk);  // idle gap
        endcase
        repeat (2 * clkDiv) @(posedge iSysClk);  // settle
        curName     <= tName[n];
        expPixel    <= tPix[n];
        expPixelCke <= tPcke[n];
        expSound    <= tSnd[n];
        expSoundCke <= tScke[n];
        expAddr     <= tAddr[n];
        checkReq    <= 1'b1;
        @(posedge iSysClk);
        checkReq    <= 1'b0;
    endtask

    // --------------------
    // main sequence
    initial
    begin
        rxd         = 1'b1;
        wdVd        = 1'b0;
        pdCmdCke    = 1'b0;
        checkReq    = 1'b0;
        sentStrobe  = 1'b0;
        summaryReq  = 1'b0;
        curName     = '0;
        sentByte    = '0;
        expPixel    = '0;
        expPixelCke = 1'b0;
        expSound    = '0;
        expSoundCke = 1'b0;
        expAddr     = '0;
        numEntries  = 0;
        sentCount   = 0;
        seed        = 23;
        tableReady  = 1'b0;
        buildTable();
        tableReady  = 1'b1;
        wait (rstN);
        for (int n = 0; n < numEntries; n++)
            applyEntry(n);
        // last echo still on the line
        drainCnt = 0;
        while (echoCount < sentCount && drainCnt < 12 * clkDiv)
        begin
            @(posedge iSysClk);
            drainCnt++;
        end
        @(posedge iSysClk);
        summaryReq <= 1'b1;
        @(posedge iSysClk);
        summaryReq <= 1'b0;
        wait (summaryDone);
        if (errTotal == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    // watchdog, sized from the table
    initial
    begin
        wait (tableReady);
        watchLimit = numEntries * (12 * clkDiv + timeoutCycles);
        repeat (watchLimit) @(posedge iSysClk);
        $display("watchdog expired after %0d cycles, the run did not finish", watchLimit);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire
